/* Makefile */
# verilator build and run of the nn testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module nn_tb -o nn_tb_sim

run: compile
	./obj_dir/nn_tb_sim | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim.f */
+incdir+src
src/nn_pkg.sv
src/param_loader.sv
src/param_arbiter.sv
src/layer_engine.sv
src/nn_top.sv
sim/nn_properties.sv
sim/nn_checker.sv
sim/nn_tb.sv

/* sim/nn_checker.sv */
`timescale 1ns/1ps

module nn_checker (
  input logic            clk,
  input logic            arst_n,
  input logic            pw_valid,
  input logic            pw_credit,
  input logic            res_valid,
  input nn_pkg::result_t res
);

  // beats the model says are coming, oldest first
  nn_pkg::result_t exp_q [$];
  nn_pkg::result_t exp_beat;

  int err_count      = 0;
  int check_count    = 0;
  int beat_count     = 0;
  int write_count    = 0;
  int credit_count   = 0;
  int test_count     = 0;
  int fail_count     = 0;
  // counters at the start of the current test
  int test_err_base  = 0;
  int test_beat_base = 0;

  function automatic void push_expected(input nn_pkg::result_t b);
    exp_q.push_back(b);
  endfunction

  function automatic int pending_beats();
    return exp_q.size();
  endfunction

  function automatic int beats_seen();
    return beat_count;
  endfunction

  function automatic int error_count();
    return err_count;
  endfunction

  function automatic void note_failure(input string what);
    $display("Error at %0t: %s", $time, what);
    err_count++;
  endfunction

  function automatic void expect_int(input string name, input int got, input int exp);
    check_count++;
    if (got != exp) begin
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      err_count++;
    end
  endfunction

  function automatic void begin_test();
    test_err_base  = err_count;
    test_beat_base = beat_count;
  endfunction

  // every write handed to the loader earns exactly one credit back
  function automatic void check_credit_balance();
    expect_int("pw_credit pulses", credit_count, write_count);
  endfunction

  function automatic void end_test(input string name);
    int errs;
    if (exp_q.size() != 0) begin
      note_failure($sformatf("%0d expected result beats never arrived", exp_q.size()));
      exp_q.delete();
    end
    errs = err_count - test_err_base;
    test_count++;
    if (errs != 0) begin
      fail_count++;
    end
    $display("test %0d %s: %s, %0d beats, %0d errors", test_count, name,
             (errs == 0) ? "ok" : "FAILED", beat_count - test_beat_base, errs);
  endfunction

  function automatic void summary();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_count, fail_count, check_count, err_count);
  endfunction

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (arst_n) begin
      if (pw_valid) begin
        write_count++;
      end
      if (pw_credit) begin
        credit_count++;
      end
      if (res_valid) begin
        beat_count++;
        if (exp_q.size() == 0) begin
          note_failure($sformatf("result beat idx %0d arrived with none expected", res.idx));
        end else begin
          exp_beat = exp_q.pop_front();
          expect_int("res.idx", int'(res.idx), int'(exp_beat.idx));
          expect_int("res.value", int'(res.value), int'(exp_beat.value));
          expect_int("res.last", int'(res.last), int'(exp_beat.last));
        end
      end
    end
  end

endmodule

/* sim/nn_properties.sv */
`timescale 1ns/1ps
`include "nn_cfg.svh"

module nn_properties (
  input logic clk,
  input logic arst_n,
  input logic ld_gnt,
  input logic eng_gnt,
  input logic pw_valid,
  input logic pw_credit,
  input logic res_valid,
  input logic res_credit
);

  // mirrors of the host and sink credit counters
  int host_crd;
  int res_crd;
  // assertion failures seen so far
  int fail_count = 0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      host_crd <= `NN_IN_CREDITS;
      res_crd  <= `NN_OUT_CREDITS;
    end else begin
      host_crd <= host_crd - int'(pw_valid) + int'(pw_credit);
      res_crd  <= res_crd - int'(res_valid) + int'(res_credit);
    end
  end

  // single port memory takes one grant per cycle
  a_gnt_onehot: assert property (@(posedge clk) disable iff (!arst_n)
    !(ld_gnt && eng_gnt))
    else begin
      fail_count++;
      $error("ld_gnt and eng_gnt high in the same cycle");
    end

  // a result beat spends a credit the engine holds
  a_res_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
    res_valid |-> (res_crd > 0))
    else begin
      fail_count++;
      $error("res_valid with no result credit left");
    end

  a_res_crd_max: assert property (@(posedge clk) disable iff (!arst_n)
    res_crd <= `NN_OUT_CREDITS)
    else begin
      fail_count++;
      $error("result credits above their maximum");
    end

  // on the host side a write needs a credit and credits never pile up
  a_host_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
    pw_valid |-> (host_crd > 0))
    else begin
      fail_count++;
      $error("pw_valid with no host credit left");
    end

  a_host_crd_max: assert property (@(posedge clk) disable iff (!arst_n)
    host_crd <= `NN_IN_CREDITS)
    else begin
      fail_count++;
      $error("host credits above the loader FIFO depth");
    end

endmodule

/* sim/nn_tb.sv */
`timescale 1ns/1ps
`include "nn_cfg.svh"

module nn_tb;

  localparam int CLK_PERIOD  = 8;
  localparam int ONE_Q       = 1 << `NN_FRAC_W;
  localparam int HALF_Q      = ONE_Q / 2;
  // worst case per run with every layer full width and two cycles per fetch
  localparam int RUN_CYCLES  = `NN_MAX_LAYERS * `NN_MAX_N * (2 * `NN_MAX_N + 4);
  localparam int LOAD_CYCLES = 2 * `NN_PARAM_DEPTH;
  localparam int STALL_CYCLES = 60;
  // five runs plus full load, one slot reload, stall window and reset
  localparam int WATCHDOG_CYCLES =
    4 * (5 * RUN_CYCLES + LOAD_CYCLES + 2 * `NN_LAYER_STRIDE + STALL_CYCLES + 20);

  logic             clk;
  logic             arst_n;
  logic             pw_valid;
  nn_pkg::pwrite_t  pw;
  logic             start;
  nn_pkg::run_cmd_t cmd;
  logic             res_credit;
  logic             pw_credit;
  logic             busy;
  logic             res_valid;
  nn_pkg::result_t  res;

  logic [31:0]  lfsr = 32'h5f29140a;
  // what the parameter memory should hold
  nn_pkg::fix_t model_mem [`NN_PARAM_DEPTH];
  int           host_credits = `NN_IN_CREDITS;
  // sink credits still to be handed back
  int           owed = 0;
  logic         hold_credits = 1'b0;

  nn_top i_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .pw_valid   (pw_valid),
    .pw         (pw),
    .start      (start),
    .cmd        (cmd),
    .res_credit (res_credit),
    .pw_credit  (pw_credit),
    .busy       (busy),
    .res_valid  (res_valid),
    .res        (res)
  );

  nn_checker i_checker (
    .clk       (clk),
    .arst_n    (arst_n),
    .pw_valid  (pw_valid),
    .pw_credit (pw_credit),
    .res_valid (res_valid),
    .res       (res)
  );

  bind nn_top nn_properties i_props (
    .clk        (clk),
    .arst_n     (arst_n),
    .ld_gnt     (ld_gnt),
    .eng_gnt    (eng_gnt),
    .pw_valid   (pw_valid),
    .pw_credit  (pw_credit),
    .res_valid  (res_valid),
    .res_credit (res_credit)
  );

  // galois lfsr with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);
      v[b] = lfsr[0];
    end
    return v;
  endfunction

  // 13 signed bits cover -1.0 up to just under 1.0
  function automatic nn_pkg::fix_t rand_fix();
    logic [31:0] r;
    r = take_bits(13);
    return {{3{r[12]}}, r[12:0]};
  endfunction

  function automatic longint sat32(input longint v);
    if (v > 64'sd2147483647) begin
      return 64'sd2147483647;
    end
    if (v < -64'sd2147483648) begin
      return -64'sd2147483648;
    end
    return v;
  endfunction

  // x/4 + 1/2 clamped to 0..1
  function automatic nn_pkg::fix_t hard_sigmoid(input longint x);
    longint y;
    y = (x >>> 2) + HALF_Q;
    if (y < 0) begin
      y = 0;
    end
    if (y > ONE_Q) begin
      y = ONE_Q;
    end
    return nn_pkg::fix_t'(y);
  endfunction

  // forward pass over model_mem with the last layer going to the checker
  function automatic void ref_forward(input nn_pkg::run_cmd_t c);
    nn_pkg::fix_t    a [`NN_MAX_N];
    nn_pkg::fix_t    y [`NN_MAX_N];
    nn_pkg::result_t beat;
    longint          acc;
    longint          w;
    int              n_in;
    int              n_out;
    int              base;
    for (int k = 0; k < `NN_MAX_N; k++) begin
      a[k] = c.in_vec[k];
      y[k] = '0;
    end
    n_in = int'(c.n_in);
    for (int l = 0; l < int'(c.n_layers); l++) begin
      base  = l * `NN_LAYER_STRIDE;
      n_out = int'(c.n_out[l]);
      for (int j = 0; j < n_out; j++) begin
        acc = 0;
        for (int i = 0; i < n_in; i++) begin
          w   = longint'(model_mem[base + j * `NN_MAX_N + i]);
          acc = sat32(acc + ((w * longint'(a[i])) >>> `NN_FRAC_W));
        end
        acc  = sat32(acc + longint'(model_mem[base + `NN_BIAS_OFS + j]));
        y[j] = hard_sigmoid(acc);
        if (l == int'(c.n_layers) - 1) begin
          beat.idx   = nn_pkg::cnt_t'(j);
          beat.value = y[j];
          beat.last  = (j == n_out - 1);
          i_checker.push_expected(beat);
        end
      end
      a    = y;
      n_in = n_out;
    end
  endfunction

  function automatic nn_pkg::run_cmd_t make_cmd(input int layers, input int n_in,
                                                input int o0, input int o1, input int o2);
    nn_pkg::run_cmd_t c;
    c.n_layers = 2'(layers);
    c.n_in     = nn_pkg::cnt_t'(n_in);
    c.n_out[0] = nn_pkg::cnt_t'(o0);
    c.n_out[1] = nn_pkg::cnt_t'(o1);
    c.n_out[2] = nn_pkg::cnt_t'(o2);
    // every lane gets a value and lanes past n_in must not matter
    for (int k = 0; k < `NN_MAX_N; k++) begin
      c.in_vec[k] = rand_fix();
    end
    return c;
  endfunction

  // called 1 ns after a rising edge and returns at the same phase
  task automatic write_param(input int a, input nn_pkg::fix_t d);
    while (host_credits == 0) begin
      @(posedge clk);
      #1;
    end
    model_mem[a] = d;
    pw_valid     = 1'b1;
    pw.addr      = nn_pkg::paddr_t'(a);
    pw.data      = d;
    host_credits--;
    @(posedge clk);
    #1;
    pw_valid = 1'b0;
  endtask

  task automatic load_slot(input int l);
    @(posedge clk);
    #1;
    for (int k = 0; k < `NN_LAYER_STRIDE; k++) begin
      write_param(l * `NN_LAYER_STRIDE + k, rand_fix());
    end
  endtask

  task automatic wait_credits_home();
    int n;
    n = 0;
    @(negedge clk);
    while (host_credits != `NN_IN_CREDITS && n < 4 * LOAD_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (host_credits != `NN_IN_CREDITS) begin
      i_checker.note_failure("loader never returned all host credits");
    end
  endtask

  task automatic start_run(input nn_pkg::run_cmd_t c);
    @(posedge clk);
    #1;
    while (busy) begin
      @(posedge clk);
      #1;
    end
    ref_forward(c);
    cmd   = c;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  // done means idle, every beat seen and every credit handed back
  task automatic wait_run_done(input string name);
    int n;
    n = 0;
    @(negedge clk);
    while ((busy || i_checker.pending_beats() != 0 || owed != 0) && n < 4 * RUN_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (n >= 4 * RUN_CYCLES) begin
      i_checker.note_failure($sformatf("%s did not finish within %0d cycles", name, n));
    end
  endtask

  task automatic wait_beats(input int target);
    int n;
    n = 0;
    while (i_checker.beats_seen() < target && n < 4 * RUN_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (i_checker.beats_seen() < target) begin
      i_checker.note_failure("result beats stopped before the credits ran out");
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // sink hands one credit back per beat unless held
  always @(negedge clk) begin
    if (arst_n && res_valid) begin
      owed++;
    end
    if (arst_n && pw_credit) begin
      host_credits++;
    end
  end

  initial begin
    res_credit = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (owed > 0 && !hold_credits) begin
        res_credit = 1'b1;
        owed--;
      end else begin
        res_credit = 1'b0;
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: simulation still running after %0d cycles", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    nn_pkg::run_cmd_t c;
    int base;
    arst_n   = 1'b0;
    pw_valid = 1'b0;
    pw       = '0;
    start    = 1'b0;
    cmd      = '0;
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // quiet after reset then fill all three layer slots
    i_checker.begin_test();
    repeat (4) begin
      @(negedge clk);
      i_checker.expect_int("busy", int'(busy), 0);
      i_checker.expect_int("res_valid", int'(res_valid), 0);
      i_checker.expect_int("pw_credit", int'(pw_credit), 0);
    end
    for (int l = 0; l < `NN_MAX_LAYERS; l++) begin
      load_slot(l);
    end
    wait_credits_home();
    i_checker.check_credit_balance();
    i_checker.end_test("reset and parameter credits");

    i_checker.begin_test();
    c = make_cmd(2, 8, 8, 8, 3);
    start_run(c);
    wait_run_done("two layer run");
    i_checker.end_test("two layers full width");

    i_checker.begin_test();
    c = make_cmd(3, 5, 3, 6, 4);
    start_run(c);
    wait_run_done("three layer run");
    i_checker.end_test("three layers narrow");

    // sink holds its credits so only the starting ones can be spent
    i_checker.begin_test();
    hold_credits = 1'b1;
    base = i_checker.beats_seen();
    c = make_cmd(2, 6, 7, 5, 1);
    start_run(c);
    wait_beats(base + `NN_OUT_CREDITS);
    repeat (STALL_CYCLES) @(negedge clk);
    i_checker.expect_int("beats while stalled", i_checker.beats_seen() - base, `NN_OUT_CREDITS);
    i_checker.expect_int("busy while stalled", int'(busy), 1);
    hold_credits = 1'b0;
    wait_run_done("stalled run");
    i_checker.end_test("result credit stall");

    // slot 2 is rewritten under a run that only reads slots 0 and 1
    i_checker.begin_test();
    c = make_cmd(2, 8, 8, 8, 2);
    start_run(c);
    load_slot(2);
    i_checker.expect_int("busy after reload", int'(busy), 1);
    wait_run_done("run under reload");
    wait_credits_home();
    c = make_cmd(3, 8, 8, 8, 8);
    start_run(c);
    wait_run_done("run on new slot");
    i_checker.check_credit_balance();
    i_checker.end_test("reload while busy");

    i_checker.summary();
    if (i_checker.error_count() == 0 && i_dut.i_props.fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* src/layer_engine.sv */
`timescale 1ns/1ps
`include "nn_cfg.svh"

module layer_engine (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             start,
  input  nn_pkg::run_cmd_t cmd,
  input  logic             gnt,
  input  nn_pkg::fix_t     rdata,
  input  logic             res_credit,
  output logic             req,
  output nn_pkg::paddr_t   addr,
  output logic             busy,
  output logic             res_valid,
  output nn_pkg::result_t  res
);

  localparam int IDX_W = $clog2(`NN_MAX_N);
  localparam int CRD_W = $clog2(`NN_OUT_CREDITS + 1);
  // 0.5 and 1.0 in Q4.12
  localparam nn_pkg::acc_t SIG_HALF = 32'sd1 <<< (`NN_FRAC_W - 1);
  localparam nn_pkg::acc_t SIG_ONE  = 32'sd1 <<< `NN_FRAC_W;

  nn_pkg::eng_state_t state;
  logic [1:0]         layer;
  // j walks neurons, i walks inputs
  nn_pkg::cnt_t       j;
  nn_pkg::cnt_t       i;
  nn_pkg::cnt_t       n_in_cur;
  logic [CRD_W-1:0]   res_credits;

  nn_pkg::run_cmd_t   cmd_q;
  nn_pkg::fix_t       act [`NN_MAX_N];
  nn_pkg::fix_t       nxt [`NN_MAX_N];
  nn_pkg::acc_t       acc;
  nn_pkg::fix_t       y_q;

  nn_pkg::cnt_t       n_out_cur;
  logic               last_in;
  logic               last_out;
  logic               last_layer;
  nn_pkg::acc_t       prod;
  nn_pkg::acc_t       bias_sum;
  nn_pkg::acc_t       sig_raw;
  nn_pkg::fix_t       sig;

  // add with clamp to the 32-bit range
  function automatic nn_pkg::acc_t sat_add(input nn_pkg::acc_t a, input nn_pkg::acc_t b);
    logic [`NN_ACC_W:0] s;
    s = {a[`NN_ACC_W-1], a} + {b[`NN_ACC_W-1], b};
    if (s[`NN_ACC_W] != s[`NN_ACC_W-1]) begin
      // overflow, sign of the true sum picks the rail
      return s[`NN_ACC_W] ? {1'b1, {(`NN_ACC_W - 1){1'b0}}} : {1'b0, {(`NN_ACC_W - 1){1'b1}}};
    end
    return s[`NN_ACC_W-1:0];
  endfunction

  assign n_out_cur  = cmd_q.n_out[layer];
  assign last_in    = (i == n_in_cur - 1'b1);
  assign last_out   = (j == n_out_cur - 1'b1);
  assign last_layer = (layer == cmd_q.n_layers - 2'd1);

  // rdata holds the weight in mac and the bias in activate
  assign prod     = nn_pkg::acc_t'(rdata) * nn_pkg::acc_t'(act[i[IDX_W-1:0]]);
  assign bias_sum = sat_add(acc, nn_pkg::acc_t'(rdata));
  // hard sigmoid, x/4 + 1/2
  assign sig_raw  = (bias_sum >>> 2) + SIG_HALF;

  always_comb begin
    if (sig_raw < 0) begin
      sig = '0;
    end else if (sig_raw > SIG_ONE) begin
      sig = SIG_ONE[`NN_FIX_W-1:0];
    end else begin
      sig = sig_raw[`NN_FIX_W-1:0];
    end
  end

  // memory requests, held until granted
  assign req = (state == nn_pkg::fetch_w) || (state == nn_pkg::fetch_b);

  always_comb begin
    if (state == nn_pkg::fetch_b) begin
      addr = nn_pkg::paddr_t'(layer * `NN_LAYER_STRIDE + `NN_BIAS_OFS + j);
    end else begin
      addr = nn_pkg::paddr_t'(layer * `NN_LAYER_STRIDE + j * `NN_MAX_N + i);
    end
  end

  // result beat only goes out with a credit in hand
  assign busy      = (state != nn_pkg::idle);
  assign res_valid = (state == nn_pkg::emit) && (res_credits != '0);
  assign res       = '{idx: j, value: y_q, last: last_out};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= nn_pkg::idle;
      layer    <= '0;
      j        <= '0;
      i        <= '0;
      n_in_cur <= '0;
    end else begin
      case (state)
        nn_pkg::idle: begin
          if (start) begin
            state    <= nn_pkg::fetch_w;
            layer    <= '0;
            j        <= '0;
            i        <= '0;
            n_in_cur <= cmd.n_in;
          end
        end
        nn_pkg::fetch_w: begin
          if (gnt) begin
            state <= nn_pkg::mac;
          end
        end
        nn_pkg::mac: begin
          if (last_in) begin
            state <= nn_pkg::fetch_b;
          end else begin
            i     <= i + 1'b1;
            state <= nn_pkg::fetch_w;
          end
        end
        nn_pkg::fetch_b: begin
          if (gnt) begin
            state <= nn_pkg::activate;
          end
        end
        nn_pkg::activate: begin
          i <= '0;
          if (last_layer) begin
            state <= nn_pkg::emit;
          end else if (last_out) begin
            // next layer reads what this one wrote
            layer    <= layer + 1'b1;
            n_in_cur <= n_out_cur;
            j        <= '0;
            state    <= nn_pkg::fetch_w;
          end else begin
            j     <= j + 1'b1;
            state <= nn_pkg::fetch_w;
          end
        end
        nn_pkg::emit: begin
          // stay here while out of credits
          if (res_valid) begin
            if (last_out) begin
              state <= nn_pkg::idle;
            end else begin
              j     <= j + 1'b1;
              state <= nn_pkg::fetch_w;
            end
          end
        end
        default: state <= nn_pkg::idle;
      endcase
    end
  end

  // sink credits
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_credits <= CRD_W'(`NN_OUT_CREDITS);
    end else begin
      case ({res_credit, res_valid})
        2'b10:   res_credits <= res_credits + 1'b1;
        2'b01:   res_credits <= res_credits - 1'b1;
        default: res_credits <= res_credits;
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (state == nn_pkg::idle && start) begin
      cmd_q <= cmd;
      acc   <= '0;
      for (int k = 0; k < `NN_MAX_N; k++) begin
        act[k] <= cmd.in_vec[k];
      end
    end
    if (state == nn_pkg::mac) begin
      acc <= sat_add(acc, prod >>> `NN_FRAC_W);
    end
    if (state == nn_pkg::activate) begin
      y_q             <= sig;
      nxt[j[IDX_W-1:0]] <= sig;
      // fresh sum for the next neuron
      acc             <= '0;
      if (!last_layer && last_out) begin
        // swap in the finished layer, newest value included
        for (int k = 0; k < `NN_MAX_N; k++) begin
          act[k] <= (k == int'(j)) ? sig : nxt[k];
        end
      end
    end
  end

endmodule

/* src/nn_cfg.svh */
`ifndef NN_CFG_SVH
`define NN_CFG_SVH

// network limits
`define NN_MAX_LAYERS 3
`define NN_MAX_N 8

// credit depths for the two streams
`define NN_IN_CREDITS 4
`define NN_OUT_CREDITS 2

// Q4.12 values and a wide accumulator
`define NN_FIX_W 16
`define NN_FRAC_W 12
`define NN_ACC_W 32
`define NN_CNT_W 4

// parameter memory map
// weights first, then the biases of the same layer
`define NN_BIAS_OFS (`NN_MAX_N * `NN_MAX_N)
`define NN_LAYER_STRIDE (`NN_MAX_N * `NN_MAX_N + `NN_MAX_N)
`define NN_PARAM_DEPTH (`NN_MAX_LAYERS * `NN_LAYER_STRIDE)
`define NN_ADDR_W 8

`endif

/* src/nn_pkg.sv */
`include "nn_cfg.svh"

package nn_pkg;

  // signed Q4.12 value
  typedef logic signed [`NN_FIX_W-1:0] fix_t;
  // accumulator
  typedef logic signed [`NN_ACC_W-1:0] acc_t;
  typedef logic [`NN_ADDR_W-1:0] paddr_t;
  // neuron count or index
  typedef logic [`NN_CNT_W-1:0] cnt_t;

  // one host write into parameter memory
  typedef struct packed {
    paddr_t addr;
    fix_t   data;
  } pwrite_t;

  // run command latched on start
  typedef struct packed {
    logic [1:0]                    n_layers;
    cnt_t                          n_in;
    cnt_t [`NN_MAX_LAYERS-1:0]     n_out;
    fix_t [`NN_MAX_N-1:0]          in_vec;
  } run_cmd_t;

  // one result beat
  typedef struct packed {
    cnt_t idx;
    fix_t value;
    logic last;
  } result_t;

  typedef enum logic [2:0] {
    idle,
    fetch_w,
    mac,
    fetch_b,
    activate,
    emit
  } eng_state_t;

endpackage

/* src/nn_top.sv */
`timescale 1ns/1ps

module nn_top (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             pw_valid,
  input  nn_pkg::pwrite_t  pw,
  input  logic             start,
  input  nn_pkg::run_cmd_t cmd,
  input  logic             res_credit,
  output logic             pw_credit,
  output logic             busy,
  output logic             res_valid,
  output nn_pkg::result_t  res
);

  // loader side of the arbiter
  logic           ld_req;
  nn_pkg::paddr_t ld_addr;
  nn_pkg::fix_t   ld_wdata;
  logic           ld_gnt;

  // engine side of the arbiter
  logic           eng_req;
  nn_pkg::paddr_t eng_addr;
  logic           eng_gnt;
  nn_pkg::fix_t   eng_rdata;

  param_loader i_loader (
    .clk       (clk),
    .arst_n    (arst_n),
    .pw_valid  (pw_valid),
    .pw        (pw),
    .gnt       (ld_gnt),
    .pw_credit (pw_credit),
    .req       (ld_req),
    .addr      (ld_addr),
    .wdata     (ld_wdata)
  );

  // shared parameter memory
  param_arbiter i_arb (
    .clk       (clk),
    .arst_n    (arst_n),
    .ld_req    (ld_req),
    .ld_addr   (ld_addr),
    .ld_wdata  (ld_wdata),
    .eng_req   (eng_req),
    .eng_addr  (eng_addr),
    .ld_gnt    (ld_gnt),
    .eng_gnt   (eng_gnt),
    .eng_rdata (eng_rdata)
  );

  layer_engine i_engine (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (start),
    .cmd        (cmd),
    .gnt        (eng_gnt),
    .rdata      (eng_rdata),
    .res_credit (res_credit),
    .req        (eng_req),
    .addr       (eng_addr),
    .busy       (busy),
    .res_valid  (res_valid),
    .res        (res)
  );

endmodule

/* src/param_arbiter.sv */
`timescale 1ns/1ps
`include "nn_cfg.svh"

module param_arbiter (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           ld_req,
  input  nn_pkg::paddr_t ld_addr,
  input  nn_pkg::fix_t   ld_wdata,
  input  logic           eng_req,
  input  nn_pkg::paddr_t eng_addr,
  output logic           ld_gnt,
  output logic           eng_gnt,
  output nn_pkg::fix_t   eng_rdata
);

  localparam int DEPTH = `NN_PARAM_DEPTH;

  // weights and biases of every layer slot
  nn_pkg::fix_t mem [DEPTH];

  // high when the engine held the last grant
  logic eng_last;

  // round robin
  // on a tie the side not served last wins
  assign ld_gnt  = ld_req & (~eng_req | eng_last);
  assign eng_gnt = eng_req & (~ld_req | ~eng_last);

  // single port
  // only one of the two grants is ever high
  always_ff @(posedge clk) begin
    if (ld_gnt) begin
      mem[ld_addr] <= ld_wdata;
    end
    if (eng_gnt) begin
      // read data shows up one cycle after the grant
      eng_rdata <= mem[eng_addr];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      eng_last <= 1'b0;
    end else begin
      if (ld_gnt) begin
        eng_last <= 1'b0;
      end else if (eng_gnt) begin
        eng_last <= 1'b1;
      end
    end
  end

endmodule

/* src/param_loader.sv */
`timescale 1ns/1ps
`include "nn_cfg.svh"

module param_loader (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            pw_valid,
  input  nn_pkg::pwrite_t pw,
  input  logic            gnt,
  output logic            pw_credit,
  output logic            req,
  output nn_pkg::paddr_t  addr,
  output nn_pkg::fix_t    wdata
);

  localparam int DEPTH = `NN_IN_CREDITS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // writes waiting for their turn at the memory
  nn_pkg::pwrite_t  fifo [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  // head entry sits on the port until granted
  assign req   = (count != '0);
  assign addr  = fifo[rd_ptr].addr;
  assign wdata = fifo[rd_ptr].data;
  assign pop   = req & gnt;
  // credit goes back in the grant cycle
  assign pw_credit = pop;

  always_ff @(posedge clk) begin
    if (pw_valid) begin
      fifo[wr_ptr] <= pw;
    end
  end

  // host never writes without a credit, so no full check here
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (pw_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({pw_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule
